// ==== design/rv32i_types.sv ====
package rv32i_types;

  localparam int xlen           = 32;
  localparam int reg_addr_width = 5;

  typedef enum logic [6:0] {
    op_lui   = 7'b0110111,
    op_auipc = 7'b0010111,
    op_jal   = 7'b1101111,
    op_jalr  = 7'b1100111,
    op_br    = 7'b1100011,
    op_load  = 7'b0000011,
    op_store = 7'b0100011,
    op_imm   = 7'b0010011,
    op_reg   = 7'b0110011
  } rv32i_opcode;

  // Branch funct3 codes double as the comparator op encoding
  typedef enum logic [2:0] {
    br_beq  = 3'b000,
    br_bne  = 3'b001,
    br_blt  = 3'b100,
    br_bge  = 3'b101,
    br_bltu = 3'b110,
    br_bgeu = 3'b111
  } branch_funct3_t;

  typedef enum logic [2:0] {
    ld_lb  = 3'b000,
    ld_lh  = 3'b001,
    ld_lw  = 3'b010,
    ld_lbu = 3'b100,
    ld_lhu = 3'b101
  } load_funct3_t;

  typedef enum logic [2:0] {
    st_sb = 3'b000,
    st_sh = 3'b001,
    st_sw = 3'b010
  } store_funct3_t;

  typedef enum logic [2:0] {
    ar_add  = 3'b000,
    ar_sll  = 3'b001,
    ar_slt  = 3'b010,
    ar_sltu = 3'b011,
    ar_xor  = 3'b100,
    ar_sr   = 3'b101,
    ar_or   = 3'b110,
    ar_and  = 3'b111
  } arith_funct3_t;

  // Fields of one instruction, immediates already sign extended
  typedef struct packed {
    rv32i_opcode               opcode;
    logic [2:0]                funct3;
    logic [6:0]                funct7;
    logic [reg_addr_width-1:0] rs1;
    logic [reg_addr_width-1:0] rs2;
    logic [reg_addr_width-1:0] rd;
    logic [xlen-1:0]           i_imm;
    logic [xlen-1:0]           s_imm;
    logic [xlen-1:0]           b_imm;
    logic [xlen-1:0]           u_imm;
    logic [xlen-1:0]           j_imm;
  } instr_struct;

endpackage

// ==== design/pipe_types.sv ====
package pipe_types;

  localparam logic [31:0] reset_pc = 32'h0;

  typedef enum logic [2:0] {
    alu_add = 3'b000,
    alu_sll = 3'b001,
    alu_sra = 3'b010,
    alu_sub = 3'b011,
    alu_xor = 3'b100,
    alu_srl = 3'b101,
    alu_or  = 3'b110,
    alu_and = 3'b111
  } alu_ops;

  typedef enum logic [2:0] {
    cmp_beq  = 3'b000,
    cmp_bne  = 3'b001,
    cmp_blt  = 3'b100,
    cmp_bge  = 3'b101,
    cmp_bltu = 3'b110,
    cmp_bgeu = 3'b111
  } cmp_ops;

  typedef enum logic {alumux1_rs1, alumux1_pc} alumux1_sel_t;

  typedef enum logic [2:0] {
    alumux2_i_imm,
    alumux2_u_imm,
    alumux2_b_imm,
    alumux2_s_imm,
    alumux2_j_imm,
    alumux2_rs2
  } alumux2_sel_t;

  typedef enum logic {cmpmux_rs2, cmpmux_i_imm} cmpmux_sel_t;

  typedef enum logic [1:0] {res_alu, res_cmp, res_pc_plus4} result_sel_t;

  typedef enum logic [2:0] {wb_result, wb_lw, wb_lh, wb_lhu, wb_lb, wb_lbu} wb_sel_t;

  typedef enum logic [1:0] {fwd_regfile, fwd_exmem, fwd_memwb} fwd_sel_t;

  // All zeros is a bubble
  typedef struct packed {
    alu_ops       aluop;
    cmp_ops       cmpop;
    alumux1_sel_t alumux1_sel;
    alumux2_sel_t alumux2_sel;
    cmpmux_sel_t  cmpmux_sel;
    result_sel_t  result_sel;
    wb_sel_t      wb_sel;
    logic         regfile_ld;
    logic         dcache_read;
    logic         dcache_write;
  } ctrl_word_struct;

endpackage

// ==== design/pipe_register.sv ====
`timescale 1ns/100ps

module pipe_register #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     load,
  input  logic     clear,
  input  payload_t d,
  output payload_t q
);

  // Clear turns the stage into a bubble
  always_ff @(posedge clk) begin
    if (reset || clear) begin
      q <= '0;
    end else if (load) begin
      q <= d;
    end
  end

endmodule

// ==== design/regfile.sv ====
`timescale 1ns/100ps

module regfile import rv32i_types::*; (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      load,
  input  logic [reg_addr_width-1:0] dest,
  input  logic [reg_addr_width-1:0] src_a,
  input  logic [reg_addr_width-1:0] src_b,
  input  logic [xlen-1:0]           in_data,
  output logic [xlen-1:0]           reg_a,
  output logic [xlen-1:0]           reg_b
);

  logic [xlen-1:0] regs [2**reg_addr_width];
  logic            write_en;

  assign write_en = load && (dest != '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      regs <= '{default: '0};
    end else if (write_en) begin
      regs[dest] <= in_data;
    end
  end

  // Writeback value bypasses the array for decode
  assign reg_a = (write_en && dest == src_a) ? in_data : regs[src_a];
  assign reg_b = (write_en && dest == src_b) ? in_data : regs[src_b];

  // x0 must stay zero across every write since reset
  x0_reads_zero: assert property (@(posedge clk) disable iff (reset)
    ((src_a == '0) -> (reg_a == '0)) && ((src_b == '0) -> (reg_b == '0)));

endmodule

// ==== design/ctrl_rom.sv ====
`timescale 1ns/100ps

module ctrl_rom import rv32i_types::*, pipe_types::*; (
  input  rv32i_opcode     opcode,
  input  logic [2:0]      funct3,
  input  logic [6:0]      funct7,
  output ctrl_word_struct ctrl_word
);

  always_comb begin
    ctrl_word = '0;
    case (opcode)
      // rs1 is zeroed at decode, so x0 + u_imm
      op_lui: begin
        ctrl_word.alumux2_sel = alumux2_u_imm;
        ctrl_word.regfile_ld  = 1'b1;
      end
      op_auipc: begin
        ctrl_word.alumux1_sel = alumux1_pc;
        ctrl_word.alumux2_sel = alumux2_u_imm;
        ctrl_word.regfile_ld  = 1'b1;
      end
      op_jal: begin
        ctrl_word.alumux1_sel = alumux1_pc;
        ctrl_word.alumux2_sel = alumux2_j_imm;
        ctrl_word.result_sel  = res_pc_plus4;
        ctrl_word.regfile_ld  = 1'b1;
      end
      op_jalr: begin
        ctrl_word.result_sel = res_pc_plus4;
        ctrl_word.regfile_ld = 1'b1;
      end
      op_br: begin
        ctrl_word.alumux2_sel = alumux2_b_imm;
        ctrl_word.cmpop       = cmp_ops'(funct3);
      end
      op_load: begin
        ctrl_word.dcache_read = 1'b1;
        ctrl_word.regfile_ld  = 1'b1;
        case (load_funct3_t'(funct3))
          ld_lb:   ctrl_word.wb_sel = wb_lb;
          ld_lbu:  ctrl_word.wb_sel = wb_lbu;
          ld_lh:   ctrl_word.wb_sel = wb_lh;
          ld_lhu:  ctrl_word.wb_sel = wb_lhu;
          default: ctrl_word.wb_sel = wb_lw;
        endcase
      end
      op_store: begin
        ctrl_word.alumux2_sel  = alumux2_s_imm;
        ctrl_word.dcache_write = 1'b1;
      end
      op_imm, op_reg: begin
        ctrl_word.regfile_ld = 1'b1;
        if (opcode == op_reg) begin
          ctrl_word.alumux2_sel = alumux2_rs2;
        end else begin
          ctrl_word.cmpmux_sel = cmpmux_i_imm;
        end
        case (arith_funct3_t'(funct3))
          ar_add:  ctrl_word.aluop = (opcode == op_reg && funct7[5]) ? alu_sub : alu_add;
          ar_sll:  ctrl_word.aluop = alu_sll;
          ar_sr:   ctrl_word.aluop = funct7[5] ? alu_sra : alu_srl;
          ar_slt: begin
            ctrl_word.cmpop      = cmp_blt;
            ctrl_word.result_sel = res_cmp;
          end
          ar_sltu: begin
            ctrl_word.cmpop      = cmp_bltu;
            ctrl_word.result_sel = res_cmp;
          end
          // xor, or, and share their funct3 encoding with the ALU op
          default: ctrl_word.aluop = alu_ops'(funct3);
        endcase
      end
      default: ctrl_word = '0;
    endcase
  end

endmodule

// ==== design/exec_unit.sv ====
`timescale 1ns/100ps

module exec_unit import rv32i_types::*, pipe_types::*; (
  input  logic [xlen-1:0] a,
  input  logic [xlen-1:0] b,
  input  logic [xlen-1:0] cmp_b,
  input  alu_ops          aluop,
  input  cmp_ops          cmpop,
  output logic [xlen-1:0] alu_out,
  output logic            br_en_cmp
);

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (aluop)
      alu_add: alu_out = a + b;
      alu_sll: alu_out = a << shamt;
      alu_sra: alu_out = $signed(a) >>> shamt;
      alu_sub: alu_out = a - b;
      alu_xor: alu_out = a ^ b;
      alu_srl: alu_out = a >> shamt;
      alu_or:  alu_out = a | b;
      default: alu_out = a & b;
    endcase
  end

  // Also drives slt and sltu results
  always_comb begin
    case (cmpop)
      cmp_beq:  br_en_cmp = (a == cmp_b);
      cmp_bne:  br_en_cmp = (a != cmp_b);
      cmp_blt:  br_en_cmp = ($signed(a) < $signed(cmp_b));
      cmp_bge:  br_en_cmp = ($signed(a) >= $signed(cmp_b));
      cmp_bltu: br_en_cmp = (a < cmp_b);
      default:  br_en_cmp = (a >= cmp_b);
    endcase
  end

endmodule

// ==== design/forwarding_unit.sv ====
`timescale 1ns/100ps

module forwarding_unit import rv32i_types::*, pipe_types::*; (
  input  instr_struct idex_instr,
  input  instr_struct exmem_instr,
  input  instr_struct memwb_instr,
  input  logic        exmem_ld,
  input  logic        memwb_ld,
  output fwd_sel_t    fwd_a_sel,
  output fwd_sel_t    fwd_b_sel
);

  // Youngest producer wins
  function automatic fwd_sel_t source_for(input logic [reg_addr_width-1:0] src);
    if (src == '0) begin
      return fwd_regfile;
    end
    if (exmem_ld && exmem_instr.rd == src) begin
      return fwd_exmem;
    end
    if (memwb_ld && memwb_instr.rd == src) begin
      return fwd_memwb;
    end
    return fwd_regfile;
  endfunction

  always_comb begin
    fwd_a_sel = source_for(idex_instr.rs1);
    fwd_b_sel = source_for(idex_instr.rs2);
  end

endmodule

// ==== design/datapath.sv ====
`timescale 1ns/100ps

module datapath import rv32i_types::*, pipe_types::*; (
  input  logic            clk,
  input  logic            reset,
  output logic [xlen-1:0] icache_address,
  output logic            icache_read,
  input  logic [xlen-1:0] icache_rdata,
  output logic [xlen-1:0] dcache_address,
  output logic            dcache_read,
  output logic            dcache_write,
  output logic [xlen-1:0] dcache_wdata,
  output logic [3:0]      dcache_mbe,
  input  logic [xlen-1:0] dcache_rdata
);

  logic [xlen-1:0] pc;
  logic [xlen-1:0] pc_target;
  logic            flush;
  logic            ifid_clear;
  instr_struct     ifid_instr;
  logic [xlen-1:0] ifid_pc;
  ctrl_word_struct ctrl_word;
  logic [xlen-1:0] rf_rs1;
  logic [xlen-1:0] rf_rs2;
  instr_struct     idex_instr;
  logic [xlen-1:0] idex_pc;
  ctrl_word_struct idex_ctrl;
  logic [xlen-1:0] idex_rs1;
  logic [xlen-1:0] idex_rs2;
  fwd_sel_t        fwd_a_sel;
  fwd_sel_t        fwd_b_sel;
  logic [xlen-1:0] rs1_fwd;
  logic [xlen-1:0] rs2_fwd;
  logic [xlen-1:0] alumux1_out;
  logic [xlen-1:0] alumux2_out;
  logic [xlen-1:0] cmpmux_out;
  logic [xlen-1:0] alu_out;
  logic            br_en_cmp;
  logic [xlen-1:0] ex_result;
  instr_struct     exmem_instr;
  ctrl_word_struct exmem_ctrl;
  logic [xlen-1:0] exmem_result;
  logic [xlen-1:0] exmem_rs2;
  instr_struct     memwb_instr;
  ctrl_word_struct memwb_ctrl;
  logic [xlen-1:0] memwb_result;
  logic [xlen-1:0] memwb_rdata;
  logic [xlen-1:0] load_shifted;
  logic [xlen-1:0] wb_data;

  function automatic instr_struct instr_decode(input logic [xlen-1:0] word);
    instr_struct instr;
    instr.opcode = rv32i_opcode'(word[6:0]);
    instr.funct3 = word[14:12];
    instr.funct7 = word[31:25];
    instr.rs1    = word[19:15];
    instr.rs2    = word[24:20];
    instr.rd     = word[11:7];
    instr.i_imm  = {{21{word[31]}}, word[30:20]};
    instr.s_imm  = {{21{word[31]}}, word[30:25], word[11:7]};
    instr.b_imm  = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
    instr.u_imm  = {word[31:12], 12'h000};
    instr.j_imm  = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
    // lui holds immediate bits where rs1 would be
    if (instr.opcode == op_lui) begin
      instr.rs1 = '0;
    end
    return instr;
  endfunction

  // Fetch predicts not taken
  always_ff @(posedge clk) begin
    if (reset) begin
      pc          <= reset_pc;
      icache_read <= 1'b0;
    end else begin
      icache_read <= 1'b1;
      if (flush) begin
        pc <= pc_target;
      end else if (icache_read) begin
        pc <= pc + 32'd4;
      end
    end
  end

  assign icache_address = pc;
  assign ifid_clear     = flush || !icache_read;

  pipe_register #(.payload_t(instr_struct)) ifid_instr_reg (
    .clk, .reset, .load(1'b1), .clear(ifid_clear),
    .d(instr_decode(icache_rdata)), .q(ifid_instr));
  pipe_register ifid_pc_reg (
    .clk, .reset, .load(1'b1), .clear(ifid_clear), .d(pc), .q(ifid_pc));

  // Decode
  regfile rf (
    .clk, .reset, .load(memwb_ctrl.regfile_ld), .dest(memwb_instr.rd),
    .src_a(ifid_instr.rs1), .src_b(ifid_instr.rs2), .in_data(wb_data),
    .reg_a(rf_rs1), .reg_b(rf_rs2));

  ctrl_rom ctrl (
    .opcode(ifid_instr.opcode), .funct3(ifid_instr.funct3),
    .funct7(ifid_instr.funct7), .ctrl_word(ctrl_word));

  pipe_register #(.payload_t(instr_struct)) idex_instr_reg (
    .clk, .reset, .load(1'b1), .clear(flush), .d(ifid_instr), .q(idex_instr));
  pipe_register #(.payload_t(ctrl_word_struct)) idex_ctrl_reg (
    .clk, .reset, .load(1'b1), .clear(flush), .d(ctrl_word), .q(idex_ctrl));
  pipe_register idex_pc_reg (
    .clk, .reset, .load(1'b1), .clear(flush), .d(ifid_pc), .q(idex_pc));
  pipe_register idex_rs1_reg (
    .clk, .reset, .load(1'b1), .clear(flush), .d(rf_rs1), .q(idex_rs1));
  pipe_register idex_rs2_reg (
    .clk, .reset, .load(1'b1), .clear(flush), .d(rf_rs2), .q(idex_rs2));

  // Execute
  forwarding_unit fwd (
    .idex_instr, .exmem_instr, .memwb_instr,
    .exmem_ld(exmem_ctrl.regfile_ld), .memwb_ld(memwb_ctrl.regfile_ld),
    .fwd_a_sel, .fwd_b_sel);

  always_comb begin
    case (fwd_a_sel)
      fwd_exmem: rs1_fwd = exmem_result;
      fwd_memwb: rs1_fwd = wb_data;
      default:   rs1_fwd = idex_rs1;
    endcase
    case (fwd_b_sel)
      fwd_exmem: rs2_fwd = exmem_result;
      fwd_memwb: rs2_fwd = wb_data;
      default:   rs2_fwd = idex_rs2;
    endcase
    alumux1_out = (idex_ctrl.alumux1_sel == alumux1_pc) ? idex_pc : rs1_fwd;
    cmpmux_out  = (idex_ctrl.cmpmux_sel == cmpmux_i_imm) ? idex_instr.i_imm : rs2_fwd;
    case (idex_ctrl.alumux2_sel)
      alumux2_u_imm: alumux2_out = idex_instr.u_imm;
      alumux2_b_imm: alumux2_out = idex_instr.b_imm;
      alumux2_s_imm: alumux2_out = idex_instr.s_imm;
      alumux2_j_imm: alumux2_out = idex_instr.j_imm;
      alumux2_rs2:   alumux2_out = rs2_fwd;
      default:       alumux2_out = idex_instr.i_imm;
    endcase
  end

  exec_unit eu (
    .a(alumux1_out), .b(alumux2_out), .cmp_b(cmpmux_out),
    .aluop(idex_ctrl.aluop), .cmpop(idex_ctrl.cmpop),
    .alu_out, .br_en_cmp);

  always_comb begin
    case (idex_ctrl.result_sel)
      res_cmp:      ex_result = {31'b0, br_en_cmp};
      res_pc_plus4: ex_result = idex_pc + 32'd4;
      default:      ex_result = alu_out;
    endcase
  end

  // Branch compares rs1 in the ALU path, so its target gets its own adder
  assign pc_target = (idex_instr.opcode == op_jalr) ? {alu_out[31:1], 1'b0}
                                                    : idex_pc + alumux2_out;
  assign flush = (idex_instr.opcode == op_br && br_en_cmp)
              || idex_instr.opcode == op_jal || idex_instr.opcode == op_jalr;

  pipe_register #(.payload_t(instr_struct)) exmem_instr_reg (
    .clk, .reset, .load(1'b1), .clear(1'b0), .d(idex_instr), .q(exmem_instr));
  pipe_register #(.payload_t(ctrl_word_struct)) exmem_ctrl_reg (
    .clk, .reset, .load(1'b1), .clear(1'b0), .d(idex_ctrl), .q(exmem_ctrl));
  pipe_register exmem_result_reg (
    .clk, .reset, .load(1'b1), .clear(1'b0), .d(ex_result), .q(exmem_result));
  pipe_register exmem_rs2_reg (
    .clk, .reset, .load(1'b1), .clear(1'b0), .d(rs2_fwd), .q(exmem_rs2));

  // Memory stage moves store data into its byte lanes
  assign dcache_address = {exmem_result[31:2], 2'b00};
  assign dcache_read    = exmem_ctrl.dcache_read;
  assign dcache_write   = exmem_ctrl.dcache_write;
  assign dcache_wdata   = exmem_rs2 << {exmem_result[1:0], 3'b000};

  always_comb begin
    case (store_funct3_t'(exmem_instr.funct3))
      st_sb:   dcache_mbe = 4'b0001 << exmem_result[1:0];
      st_sh:   dcache_mbe = 4'b0011 << exmem_result[1:0];
      st_sw:   dcache_mbe = 4'b1111;
      default: dcache_mbe = 4'b0000;
    endcase
  end

  pipe_register #(.payload_t(instr_struct)) memwb_instr_reg (
    .clk, .reset, .load(1'b1), .clear(1'b0), .d(exmem_instr), .q(memwb_instr));
  pipe_register #(.payload_t(ctrl_word_struct)) memwb_ctrl_reg (
    .clk, .reset, .load(1'b1), .clear(1'b0), .d(exmem_ctrl), .q(memwb_ctrl));
  pipe_register memwb_result_reg (
    .clk, .reset, .load(1'b1), .clear(1'b0), .d(exmem_result), .q(memwb_result));
  pipe_register memwb_rdata_reg (
    .clk, .reset, .load(1'b1), .clear(1'b0), .d(dcache_rdata), .q(memwb_rdata));

  // Writeback brings the addressed lane down to bit 0
  assign load_shifted = memwb_rdata >> {memwb_result[1:0], 3'b000};

  always_comb begin
    case (memwb_ctrl.wb_sel)
      wb_lw:   wb_data = memwb_rdata;
      wb_lh:   wb_data = {{16{load_shifted[15]}}, load_shifted[15:0]};
      wb_lhu:  wb_data = {16'b0, load_shifted[15:0]};
      wb_lb:   wb_data = {{24{load_shifted[7]}}, load_shifted[7:0]};
      wb_lbu:  wb_data = {24'b0, load_shifted[7:0]};
      default: wb_data = memwb_result;
    endcase
  end

  mem_strobes_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(dcache_read && dcache_write));

  // Control word and funct3 travel in separate registers
  store_has_lanes: assert property (@(posedge clk) disable iff (reset)
    dcache_write |-> dcache_mbe != 4'b0000);

  // Redirect targets must keep the fetch stream aligned
  fetch_word_aligned: assert property (@(posedge clk) disable iff (reset)
    icache_read |-> icache_address[1:0] == 2'b00);

endmodule

// ==== tests/store_checker.sv ====
`timescale 1ns/100ps

module store_checker import rv32i_types::*; #(
  parameter int imem_words = 512,
  parameter int dmem_words = 1024
) (
  input  logic        clk,
  input  logic        reset,
  input  logic [31:0] icache_address,
  input  logic        icache_read,
  input  logic        dcache_read,
  input  logic        dcache_write,
  input  logic [31:0] dcache_address,
  input  logic [31:0] dcache_wdata,
  input  logic [3:0]  dcache_mbe,
  input  logic [31:0] imem [imem_words],
  input  logic [31:0] dmem_init [dmem_words],
  output int          expected_count,
  output int          store_count,
  output int          error_count
);

  localparam int max_steps = 4096;

  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  logic [3:0]  exp_mbe [$];
  int          store_errors;
  int          reset_errors;
  bit          built;
  bit          fetch_pending;

  assign error_count = store_errors + reset_errors;

  function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
    case (branch_funct3_t'(f3))
      br_beq:  return a == b;
      br_bne:  return a != b;
      br_blt:  return $signed(a) < $signed(b);
      br_bge:  return $signed(a) >= $signed(b);
      br_bltu: return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic logic [31:0] alu_value(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000: return alt ? a - b : a + b;
      3'b001: return a << b[4:0];
      3'b010: return {31'b0, $signed(a) < $signed(b)};
      3'b011: return {31'b0, a < b};
      3'b100: return a ^ b;
      3'b101: begin
        if (alt) begin
          return $signed(a) >>> b[4:0];
        end
        return a >> b[4:0];
      end
      3'b110: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic [31:0] load_value(input logic [2:0] f3, input logic [31:0] word,
                                             input logic [1:0] offset);
    logic [7:0]  byte_val;
    logic [15:0] half_val;
    byte_val = word[8*offset +: 8];
    half_val = word[16*offset[1] +: 16];
    case (load_funct3_t'(f3))
      ld_lb:   return {{24{byte_val[7]}}, byte_val};
      ld_lbu:  return {24'b0, byte_val};
      ld_lh:   return {{16{half_val[15]}}, half_val};
      ld_lhu:  return {16'b0, half_val};
      default: return word;
    endcase
  endfunction

  function automatic logic [31:0] lane_mask(input logic [3:0] mbe);
    return {{8{mbe[3]}}, {8{mbe[2]}}, {8{mbe[1]}}, {8{mbe[0]}}};
  endfunction

  // In-order ISA model that runs to the closing jal-to-self
  task automatic build_expected();
    logic [31:0] x [32];
    logic [31:0] mem [dmem_words];
    logic [31:0] w;
    logic [31:0] pc;
    logic [31:0] next_pc;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] addr;
    logic [31:0] imm_i;
    logic [31:0] data;
    logic [3:0]  mbe;
    logic [2:0]  f3;
    rv32i_opcode op;
    int          steps;
    exp_addr.delete();
    exp_data.delete();
    exp_mbe.delete();
    for (int i = 0; i < 32; i++) begin
      x[i] = '0;
    end
    mem = dmem_init;
    pc = '0;
    for (steps = 0; steps < max_steps; steps++) begin
      w = imem[(pc >> 2) % imem_words];
      if (w == 32'h0000_006f) begin
        break;
      end
      op = rv32i_opcode'(w[6:0]);
      f3 = w[14:12];
      a = x[w[19:15]];
      b = x[w[24:20]];
      imm_i = {{20{w[31]}}, w[31:20]};
      next_pc = pc + 32'd4;
      res = pc + 32'd4;
      case (op)
        op_lui:   res = {w[31:12], 12'h000};
        op_auipc: res = pc + {w[31:12], 12'h000};
        op_jal:   next_pc = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        op_jalr:  next_pc = (a + imm_i) & ~32'd1;
        op_br: begin
          if (branch_taken(f3, a, b)) begin
            next_pc = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
          end
        end
        op_load: begin
          addr = a + imm_i;
          res = load_value(f3, mem[(addr >> 2) % dmem_words], addr[1:0]);
        end
        op_store: begin
          addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
          case (f3)
            3'b000: begin
              mbe = 4'b0001 << addr[1:0];
              data = {4{b[7:0]}};
            end
            3'b001: begin
              mbe = 4'b0011 << addr[1:0];
              data = {2{b[15:0]}};
            end
            default: begin
              mbe = 4'b1111;
              data = b;
            end
          endcase
          for (int k = 0; k < 4; k++) begin
            if (mbe[k]) begin
              mem[(addr >> 2) % dmem_words][8*k +: 8] = data[8*k +: 8];
            end
          end
          exp_addr.push_back({addr[31:2], 2'b00});
          exp_data.push_back(data);
          exp_mbe.push_back(mbe);
        end
        op_imm: res = alu_value(f3, w[30] && f3 == 3'b101, a, imm_i);
        op_reg: res = alu_value(f3, w[30], a, b);
        default: begin
          $display("Reference model found an unknown instruction %h at pc %h", w, pc);
          store_errors++;
          break;
        end
      endcase
      if (op != op_br && op != op_store && w[11:7] != 5'd0) begin
        x[w[11:7]] = res;
      end
      pc = next_pc;
    end
    if (steps == max_steps) begin
      $display("Reference model never reached the closing jal");
      store_errors++;
    end
    expected_count = exp_addr.size();
  endtask

  always @(posedge clk) begin
    if (reset) begin
      if (!built) begin
        build_expected();
        built = 1'b1;
      end
      store_count = 0;
      fetch_pending = 1'b1;
    end else begin
      built = 1'b0;
      if (fetch_pending && icache_read) begin
        if (icache_address !== 32'h0) begin
          $display("First fetch after reset went to %h instead of address 0 at %0t",
                   icache_address, $time);
          store_errors++;
        end
        fetch_pending = 1'b0;
      end
      if (dcache_write) begin
        if (store_count >= expected_count) begin
          $display("Unexpected store to %h beyond the expected stream at %0t",
                   dcache_address, $time);
          store_errors++;
        end else if (dcache_address !== exp_addr[store_count]
                     || dcache_mbe !== exp_mbe[store_count]
                     || (dcache_wdata & lane_mask(exp_mbe[store_count]))
                        !== (exp_data[store_count] & lane_mask(exp_mbe[store_count]))) begin
          $display("mismatch at %0t: store %0d expected addr %h data %h mbe %b, got %h %h %b",
                   $time, store_count, exp_addr[store_count], exp_data[store_count],
                   exp_mbe[store_count], dcache_address, dcache_wdata, dcache_mbe);
          store_errors++;
        end
        store_count++;
      end
    end
  end

  // Strobes must stay quiet while reset holds
  always @(negedge clk) begin
    if (reset && (icache_read !== 1'b0 || dcache_read !== 1'b0 || dcache_write !== 1'b0)) begin
      $display("Memory strobe active during reset at %0t", $time);
      reset_errors++;
    end
  end

endmodule

// ==== tests/tb_datapath.sv ====
`timescale 1ns/100ps

module tb_datapath;

  localparam int          imem_words  = 512;
  localparam int          dmem_words  = 1024;
  localparam int          body_length = 40;
  localparam int          max_cycles  = 4000;
  localparam logic [31:0] nop         = 32'h0000_0013;

  logic        clk = 1'b0;
  logic        reset = 1'b1;
  logic [31:0] icache_address;
  logic        icache_read;
  logic [31:0] icache_rdata;
  logic [31:0] dcache_address;
  logic        dcache_read;
  logic        dcache_write;
  logic [31:0] dcache_wdata;
  logic [3:0]  dcache_mbe;
  logic [31:0] dcache_rdata;
  logic [31:0] imem [imem_words];
  logic [31:0] dmem [dmem_words];
  int          prog_len;
  int          expected_count;
  int          store_count;
  int          error_count;
  int          failed;
  int          errors_before;
  int          cycles;
  string       names [4];

  always #2 clk = ~clk;

  datapath dut0 (.*);

  store_checker #(.imem_words(imem_words), .dmem_words(dmem_words)) chk (
    .clk, .reset, .icache_address, .icache_read, .dcache_read, .dcache_write,
    .dcache_address, .dcache_wdata, .dcache_mbe, .imem, .dmem_init(dmem),
    .expected_count, .store_count, .error_count);

  // Both memories answer in the same cycle
  assign icache_rdata = imem[(icache_address >> 2) % imem_words];
  // Data only while a read is strobed
  assign dcache_rdata = dcache_read ? dmem[(dcache_address >> 2) % dmem_words] : 'x;

  always @(posedge clk) begin
    if (dcache_write) begin
      for (int b = 0; b < 4; b++) begin
        if (dcache_mbe[b]) begin
          dmem[(dcache_address >> 2) % dmem_words][8*b +: 8] <= dcache_wdata[8*b +: 8];
        end
      end
    end
  end

  task automatic emit(input logic [31:0] word);
    imem[prog_len] = word;
    prog_len++;
  endtask

  function automatic logic [4:0] rand_reg();
    return 5'($urandom_range(31, 1));
  endfunction

  function automatic logic [31:0] rand_alu(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
    logic [2:0] f3;
    logic       alt;
    f3 = 3'($urandom);
    alt = 1'($urandom);
    if ($urandom % 2 == 0) begin
      // Register form sets funct7 bit 5 only for sub and sra
      return {1'b0, alt && (f3 == 3'b000 || f3 == 3'b101), 5'b0, rs2, rs1, f3, rd, 7'b0110011};
    end
    if (f3 == 3'b001 || f3 == 3'b101) begin
      return {1'b0, alt && f3 == 3'b101, 5'b0, rs2, rs1, f3, rd, 7'b0010011};
    end
    return {12'($urandom), rs1, f3, rd, 7'b0010011};
  endfunction

  task automatic gen_program(input int kind);
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  prev [2];
    logic [2:0]  f3;
    logic [11:0] off;
    int          sel;
    prog_len = 0;
    prev[0] = 5'd1;
    prev[1] = 5'd2;
    for (int i = 0; i < imem_words; i++) begin
      imem[i] = '0;
    end
    for (int i = 0; i < dmem_words; i++) begin
      dmem[i] <= (i * 32'h9e37_79b9) ^ 32'h5bd1_e995;
    end
    // Random starting value in every register
    for (int r = 1; r < 32; r++) begin
      emit({20'($urandom), 5'(r), 7'b0110111});
      emit({12'($urandom), 5'(r), 3'b000, 5'(r), 7'b0010011});
    end
    for (int i = 0; i < body_length; i++) begin
      rd = rand_reg();
      rs1 = rand_reg();
      rs2 = rand_reg();
      if (kind == 1) begin
        rs1 = prev[$urandom % 2];
        rs2 = prev[$urandom % 2];
        prev[1] = prev[0];
        prev[0] = rd;
      end
      if (kind == 2) begin
        f3 = 3'($urandom % 3);
        off = 12'h100 + 12'($urandom % 256);
        off = off & ~((12'd1 << f3) - 12'd1);
        if ($urandom % 2) begin
          emit({off[11:5], rs2, 5'd0, f3, off[4:0], 7'b0100011});
        end else begin
          if (f3 != 3'b010 && $urandom % 2) begin
            f3 = f3 | 3'b100;
          end
          emit({off, 5'd0, f3, rd, 7'b0000011});
          // Keeps the loaded register out of the next instruction
          emit(nop);
        end
      end else if (kind == 3 && i % 2 == 0) begin
        sel = $urandom % 3;
        if (sel == 0) begin
          f3 = 3'($urandom % 6);
          if (f3 > 3'd1) begin
            f3 = f3 + 3'd2;
          end
          if ($urandom % 4 == 0) begin
            rs2 = rs1;
          end
          emit({7'd0, rs2, rs1, f3, 5'b01100, 7'b1100011});
        end else if (sel == 1) begin
          emit({1'b0, 10'd6, 1'b0, 8'd0, rd, 7'b1101111});
        end else begin
          // auipc gives the base and jalr jumps past both shadow slots
          emit({20'd0, rs1, 7'b0010111});
          emit({12'd16, rs1, 3'b000, rd, 7'b1100111});
        end
        emit({12'h7ff, 5'd0, 3'b000, rand_reg(), 7'b0010011});
        emit({12'h7fe, 5'd0, 3'b000, rand_reg(), 7'b0010011});
      end else begin
        emit(rand_alu(rd, rs1, rs2));
      end
    end
    emit(nop);
    for (int r = 1; r < 32; r++) begin
      off = 12'h400 + 12'(4 * r);
      emit({off[11:5], 5'(r), 5'd0, 3'b010, off[4:0], 7'b0100011});
    end
    emit(32'h0000_006f);
  endtask

  initial begin
    names = '{"alu", "dependency", "load/store", "branch/jump"};
    failed = 0;
    void'($urandom(32'hb88f_b122));
    for (int k = 0; k < 4; k++) begin
      errors_before = error_count;
      gen_program(k);
      reset <= 1'b1;
      repeat (5) @(negedge clk);
      reset <= 1'b0;
      cycles = 0;
      while (store_count < expected_count && cycles < max_cycles) begin
        @(negedge clk);
        cycles++;
      end
      if (store_count < expected_count) begin
        $display("test %0d (%s) timed out: %0d of %0d stores seen after %0d cycles",
                 k, names[k], store_count, expected_count, cycles);
        failed++;
      end else if (error_count != errors_before) begin
        $display("test %0d (%s) failed: %0d stores, %0d errors",
                 k, names[k], store_count, error_count - errors_before);
        failed++;
      end else begin
        $display("test %0d (%s) passed: %0d stores checked", k, names[k], store_count);
      end
    end
    $display("tests run: 4, tests failed: %0d, errors: %0d", failed, error_count);
    if (failed == 0 && error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== list.f ====
design/rv32i_types.sv
design/pipe_types.sv
design/pipe_register.sv
design/regfile.sv
design/ctrl_rom.sv
design/exec_unit.sv
design/forwarding_unit.sv
design/datapath.sv
tests/store_checker.sv
tests/tb_datapath.sv
